// ==== Bender.yml ====
package:
  name: neural_chip

sources:
  - hdl/nc_pkg.sv
  - hdl/bf16_pe.sv
  - hdl/step_counter.sv
  - hdl/frame_receiver.sv
  - hdl/matmul_control.sv
  - hdl/systolic_array.sv
  - hdl/result_sender.sv
  - hdl/neural_chip.sv
  - target: simulation
    files:
      - sim/tb_neural_chip.sv

// ==== hdl/bf16_pe.sv ====
`timescale 1ns/1ps

module bf16_pe import nc_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  bf16_t act_i,        // From the west
    input  bf16_t psum_i,       // From the north
    input  bf16_t weight_i,
    input  logic  weight_en_i,
    input  logic  compute_i,
    output bf16_t act_o,        // To the east
    output bf16_t psum_o        // To the south
);

    // Truncating multiply, zero exponent gives signed zero
    function automatic bf16_t bf16_mul(bf16_t a, bf16_t b);
        logic                 sign;
        logic [EXP_W-1:0]     ea, eb;
        logic [2*MAN_W+1:0]   prod;      // 1.m x 1.m, up to 4.0
        logic [EXP_W+1:0]     esum;
        logic [MAN_W-1:0]     man;
        sign = a[BF16_W-1] ^ b[BF16_W-1];
        ea   = a[BF16_W-2:MAN_W];
        eb   = b[BF16_W-2:MAN_W];
        prod = {1'b1, a[MAN_W-1:0]} * {1'b1, b[MAN_W-1:0]};
        man  = prod[2*MAN_W+1] ? prod[2*MAN_W:MAN_W+1] : prod[2*MAN_W-1:MAN_W];
        esum = {2'b00, ea} + {2'b00, eb} + prod[2*MAN_W+1];
        if (ea == '0 || eb == '0) return {sign, {(BF16_W-1){1'b0}}};
        // Out of range either way saturates the exponent, the adder then kills it
        if (esum <= EXP_BIAS || esum >= EXP_BIAS + (2**EXP_W - 1))
            return {sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
        return {sign, EXP_W'(esum - EXP_BIAS), man};
    endfunction

    // Same-sign add only, mixed signs collapse to zero
    function automatic bf16_t bf16_add(bf16_t x, bf16_t y);
        bf16_t            hi, lo;
        logic [EXP_W-1:0] ediff;
        logic [MAN_W:0]   sig_lo;
        logic [MAN_W+1:0] sum;
        if (&x[BF16_W-2:MAN_W] || &y[BF16_W-2:MAN_W]) return '0;  // Inf/NaN
        if (y[BF16_W-2:MAN_W] == '0) return x;                     // Zero adds nothing
        if (x[BF16_W-2:MAN_W] == '0) return y;
        if (x[BF16_W-1] != y[BF16_W-1]) return '0;
        {hi, lo} = (x[BF16_W-2:0] < y[BF16_W-2:0]) ? {y, x} : {x, y};
        ediff  = hi[BF16_W-2:MAN_W] - lo[BF16_W-2:MAN_W];
        sig_lo = {1'b1, lo[MAN_W-1:0]} >> ediff;                   // Align to larger
        sum    = {1'b1, hi[MAN_W-1:0]} + sig_lo;
        if (sum[MAN_W+1])
            return {hi[BF16_W-1], hi[BF16_W-2:MAN_W] + 1'b1, sum[MAN_W:1]};
        return {hi[BF16_W-1], hi[BF16_W-2:MAN_W], sum[MAN_W-1:0]};
    endfunction

    bf16_t weight_q;
    bf16_t prod_w;
    bf16_t sum_w;

    assign prod_w = bf16_mul(act_i, weight_q);
    assign sum_w  = bf16_add(psum_i, prod_w);

    // Weight only changes on load
    always_ff @(posedge clk) begin
        if (weight_en_i) weight_q <= weight_i;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            act_o  <= '0;
            psum_o <= '0;
        end else if (compute_i) begin
            act_o  <= act_i;       // Pass activation on unchanged
            psum_o <= sum_w;
        end
    end

endmodule

// ==== hdl/frame_receiver.sv ====
`timescale 1ns/1ps

module frame_receiver import nc_pkg::*; #(
    parameter int ARRAY_N = 2
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  rx_valid_i,
    input  byte_t rx_data_i,
    input  logic  busy_i,                           // Engine not idle, drop bytes
    output logic  frame_done_o,
    output bf16_t a_elems_o [ARRAY_N][ARRAY_N],
    output bf16_t b_elems_o [ARRAY_N][ARRAY_N]
);

    localparam int N_ELEMS    = ARRAY_N * ARRAY_N;  // Per matrix
    localparam int OPER_BYTES = 4 * N_ELEMS;         // A then B, two bytes each
    localparam int IDX_W      = $clog2(OPER_BYTES);

    rx_state_t        state_q;
    logic [IDX_W-1:0] byte_idx;
    logic [IDX_W-2:0] elem_idx;
    logic             hi_byte;
    logic             take_operand;

    assign elem_idx     = byte_idx[IDX_W-1:1];   // A elements first, then B
    assign hi_byte      = ~byte_idx[0];          // High byte arrives first
    assign take_operand = rx_valid_i && !busy_i && (state_q == RX_OPERANDS);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q      <= RX_WAIT_START;
            byte_idx     <= '0;
            frame_done_o <= 1'b0;
        end else begin
            frame_done_o <= 1'b0;
            if (busy_i) begin
                state_q <= RX_WAIT_START;        // Whole frame discarded
            end else if (rx_valid_i) begin
                case (state_q)
                    RX_WAIT_START: if (rx_data_i == FRAME_START) begin
                        state_q  <= RX_OPERANDS;
                        byte_idx <= '0;
                    end
                    RX_OPERANDS: begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == IDX_W'(OPER_BYTES - 1)) state_q <= RX_WAIT_END;
                    end
                    RX_WAIT_END: if (rx_data_i == FRAME_END) begin
                        state_q      <= RX_WAIT_START;
                        frame_done_o <= 1'b1;
                    end
                    default: state_q <= RX_WAIT_START;
                endcase
            end
        end
    end

    // Operand storage, held until the next frame overwrites it
    always_ff @(posedge clk) begin
        if (take_operand) begin
            for (int r = 0; r < ARRAY_N; r++) begin
                for (int c = 0; c < ARRAY_N; c++) begin
                    if (elem_idx == r * ARRAY_N + c) begin
                        if (hi_byte) a_elems_o[r][c][BF16_W-1:8] <= rx_data_i;
                        else a_elems_o[r][c][7:0] <= rx_data_i;
                    end
                    if (elem_idx == N_ELEMS + r * ARRAY_N + c) begin
                        if (hi_byte) b_elems_o[r][c][BF16_W-1:8] <= rx_data_i;
                        else b_elems_o[r][c][7:0] <= rx_data_i;
                    end
                end
            end
        end
    end

endmodule

// ==== hdl/matmul_control.sv ====
`timescale 1ns/1ps

module matmul_control import nc_pkg::*; #(
    parameter int ARRAY_N = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic frame_done_i,
    input  logic last_step_i,
    input  logic send_done_i,
    output logic busy_o,
    output logic load_o,
    output logic compute_o,
    output logic capture_o,
    output logic send_start_o,
    output logic mult_done_o
);

    ctrl_state_t state_q, state_d;
    logic        done_q;

    assign busy_o       = (state_q != CTRL_IDLE);
    assign load_o       = (state_q == CTRL_LOAD);    // Exactly one cycle
    assign compute_o    = (state_q == CTRL_COMPUTE);
    assign capture_o    = compute_o && last_step_i;
    assign send_start_o = done_q;
    assign mult_done_o  = done_q;                    // One cycle after capture

    always_comb begin
        state_d = state_q;
        case (state_q)
            CTRL_IDLE:    if (frame_done_i) state_d = CTRL_LOAD;
            CTRL_LOAD:    state_d = CTRL_COMPUTE;
            CTRL_COMPUTE: if (last_step_i) state_d = CTRL_SEND;
            CTRL_SEND:    if (send_done_i) state_d = CTRL_IDLE;
            default:      state_d = CTRL_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q <= CTRL_IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= capture_o;
        end
    end

endmodule

// ==== hdl/nc_pkg.sv ====
package nc_pkg;

    // bfloat16 field layout
    localparam int BF16_W   = 16;   // One element, one word
    localparam int EXP_W    = 8;    // Exponent field
    localparam int MAN_W    = 7;    // Stored mantissa, hidden bit not included
    localparam int EXP_BIAS = 127;

    // Matrix element, operand or partial sum
    typedef logic [BF16_W-1:0] bf16_t;

    // One byte of the host stream
    typedef logic [7:0] byte_t;

    // Framing bytes, same values in both directions
    localparam byte_t FRAME_START = 8'hFE;
    localparam byte_t FRAME_END   = 8'hFF;

    // Sequencer states
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_LOAD,      // Weights and skewed A go in
        CTRL_COMPUTE,   // Array runs, counter steps
        CTRL_SEND       // Result frame goes out
    } ctrl_state_t;

    // Receive parser states
    typedef enum logic [1:0] {
        RX_WAIT_START,
        RX_OPERANDS,
        RX_WAIT_END
    } rx_state_t;

    // Transmit states
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_END
    } tx_state_t;

endpackage

// ==== hdl/neural_chip.sv ====
`timescale 1ns/1ps

module neural_chip import nc_pkg::*; #(
    parameter int ARRAY_N = 2
) (
    input  logic  clk,
    input  logic  reset,          // Active low, asynchronous
    input  logic  rx_valid_i,     // One strobe per received byte
    input  byte_t rx_data_i,
    input  logic  tx_ready_i,     // Transmitter can take a byte
    output logic  tx_valid_o,
    output byte_t tx_data_o,
    output logic  mult_done_o     // C has been captured
);

    localparam int COMPUTE_STEPS = 3 * ARRAY_N;  // Skew in, accumulate, de-skew

    logic  frame_done, busy;
    logic  load, compute, capture;
    logic  last_step;
    logic  send_start, send_done;
    bf16_t a_elems [ARRAY_N][ARRAY_N];
    bf16_t b_elems [ARRAY_N][ARRAY_N];
    bf16_t c_elems [ARRAY_N][ARRAY_N];

    frame_receiver #(.ARRAY_N(ARRAY_N)) u_rx (
        .clk, .reset,
        .rx_valid_i, .rx_data_i,
        .busy_i       (busy),
        .frame_done_o (frame_done),
        .a_elems_o    (a_elems),
        .b_elems_o    (b_elems)
    );

    matmul_control #(.ARRAY_N(ARRAY_N)) u_ctrl (
        .clk, .reset,
        .frame_done_i (frame_done),
        .last_step_i  (last_step),
        .send_done_i  (send_done),
        .busy_o       (busy),
        .load_o       (load),
        .compute_o    (compute),
        .capture_o    (capture),
        .send_start_o (send_start),
        .mult_done_o
    );

    step_counter #(.COUNT_MAX(COMPUTE_STEPS)) u_steps (
        .clk, .reset,
        .count_en_i (compute),
        .last_o     (last_step)
    );

    systolic_array #(.ARRAY_N(ARRAY_N)) u_array (
        .clk, .reset,
        .a_elems_i (a_elems), .b_elems_i (b_elems),
        .load_i    (load), .compute_i (compute), .capture_i (capture),
        .c_elems_o (c_elems)
    );

    result_sender #(.ARRAY_N(ARRAY_N)) u_tx (
        .clk, .reset,
        .start_i   (send_start),
        .c_elems_i (c_elems),
        .tx_ready_i,
        .tx_valid_o, .tx_data_o,
        .done_o    (send_done)
    );

endmodule

// ==== hdl/result_sender.sv ====
`timescale 1ns/1ps

module result_sender import nc_pkg::*; #(
    parameter int ARRAY_N = 2
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  start_i,
    input  bf16_t c_elems_i [ARRAY_N][ARRAY_N],
    input  logic  tx_ready_i,
    output logic  tx_valid_o,
    output byte_t tx_data_o,
    output logic  done_o           // After FRAME_END went out
);

    localparam int DATA_BYTES = 2 * ARRAY_N * ARRAY_N;
    localparam int IDX_W      = $clog2(DATA_BYTES);

    tx_state_t        state_q;
    logic [IDX_W-1:0] byte_idx;
    logic             gap_q;       // Forces an idle cycle after each strobe
    bf16_t            elem;

    // Row-major element, high byte first
    always_comb begin
        elem = '0;
        for (int r = 0; r < ARRAY_N; r++) begin
            for (int c = 0; c < ARRAY_N; c++) begin
                if (byte_idx[IDX_W-1:1] == r * ARRAY_N + c) elem = c_elems_i[r][c];
            end
        end
        case (state_q)
            TX_START: tx_data_o = FRAME_START;
            TX_DATA:  tx_data_o = byte_idx[0] ? elem[7:0] : elem[BF16_W-1:8];
            TX_END:   tx_data_o = FRAME_END;
            default:  tx_data_o = '0;
        endcase
    end

    assign tx_valid_o = (state_q != TX_IDLE) && tx_ready_i && !gap_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q  <= TX_IDLE;
            byte_idx <= '0;
            gap_q    <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            gap_q  <= tx_valid_o;
            done_o <= tx_valid_o && (state_q == TX_END);
            case (state_q)
                TX_IDLE:  if (start_i) state_q <= TX_START;
                TX_START: if (tx_valid_o) begin
                    state_q  <= TX_DATA;
                    byte_idx <= '0;
                end
                TX_DATA:  if (tx_valid_o) begin
                    byte_idx <= byte_idx + 1'b1;
                    if (byte_idx == IDX_W'(DATA_BYTES - 1)) state_q <= TX_END;
                end
                TX_END:   if (tx_valid_o) state_q <= TX_IDLE;
                default:  state_q <= TX_IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/step_counter.sv ====
`timescale 1ns/1ps

module step_counter #(
    parameter int COUNT_MAX = 6
) (
    input  logic clk,
    input  logic reset,
    input  logic count_en_i,    // Low clears, high counts
    output logic last_o         // Final step of the run
);

    localparam int CNT_W = $clog2(COUNT_MAX + 1);

    logic [CNT_W-1:0] count_q;

    assign last_o = count_en_i && (count_q == CNT_W'(COUNT_MAX - 1));

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            count_q <= '0;
        end else if (!count_en_i) begin
            count_q <= '0;
        end else if (count_q != CNT_W'(COUNT_MAX - 1)) begin
            count_q <= count_q + 1'b1;  // Saturates on the last step
        end
    end

endmodule

// ==== hdl/systolic_array.sv ====
`timescale 1ns/1ps

module systolic_array import nc_pkg::*; #(
    parameter int ARRAY_N = 2
) (
    input  logic  clk,
    input  logic  reset,
    input  bf16_t a_elems_i [ARRAY_N][ARRAY_N],
    input  bf16_t b_elems_i [ARRAY_N][ARRAY_N],
    input  logic  load_i,
    input  logic  compute_i,
    input  logic  capture_i,
    output bf16_t c_elems_o [ARRAY_N][ARRAY_N]
);

    localparam int SKEW_LEN = 2 * ARRAY_N - 1;   // Longest skew plus one column

    bf16_t      skew_q   [ARRAY_N][SKEW_LEN];    // Per row, slot 0 feeds the west edge
    bf16_t      deskew_q [ARRAY_N][SKEW_LEN];    // Per column, slot 0 is newest
    wire bf16_t act_w    [ARRAY_N][ARRAY_N+1];   // Eastward activations
    wire bf16_t psum_w   [ARRAY_N+1][ARRAY_N];   // Southward partial sums

    // Row r carries column r of A, A[i][r] lands in slot i + r
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int r = 0; r < ARRAY_N; r++) begin
                for (int j = 0; j < SKEW_LEN; j++) skew_q[r][j] <= '0;
            end
        end else if (load_i) begin
            for (int r = 0; r < ARRAY_N; r++) begin
                for (int j = 0; j < SKEW_LEN; j++) skew_q[r][j] <= '0;
                for (int i = 0; i < ARRAY_N; i++) skew_q[r][i + r] <= a_elems_i[i][r];
            end
        end else if (compute_i) begin
            for (int r = 0; r < ARRAY_N; r++) begin
                for (int j = 0; j < SKEW_LEN - 1; j++) skew_q[r][j] <= skew_q[r][j + 1];
                skew_q[r][SKEW_LEN-1] <= '0;    // Zeros trail the data
            end
        end
    end

    // C[i][c] leaves the bottom in step i + N + c, capture happens in step 3N-1
    always_ff @(posedge clk) begin
        if (compute_i) begin
            for (int c = 0; c < ARRAY_N; c++) begin
                deskew_q[c][0] <= psum_w[ARRAY_N][c];
                for (int j = 1; j < SKEW_LEN; j++) deskew_q[c][j] <= deskew_q[c][j - 1];
            end
        end
        if (capture_i) begin
            for (int i = 0; i < ARRAY_N; i++) begin
                for (int c = 0; c < ARRAY_N; c++) begin
                    c_elems_o[i][c] <= deskew_q[c][2 * ARRAY_N - 2 - i - c];
                end
            end
        end
    end

    for (genvar r = 0; r < ARRAY_N; r++) begin : g_row
        assign act_w[r][0] = skew_q[r][0];
        for (genvar c = 0; c < ARRAY_N; c++) begin : g_col
            if (r == 0) begin : g_top
                assign psum_w[0][c] = '0;      // Nothing accumulated above the top row
            end
            bf16_pe u_pe (
                .clk, .reset,
                .act_i       (act_w[r][c]),
                .psum_i      (psum_w[r][c]),
                .weight_i    (b_elems_i[r][c]),   // B stays put, B[r][c] here
                .weight_en_i (load_i),
                .compute_i,
                .act_o       (act_w[r][c+1]),
                .psum_o      (psum_w[r+1][c])
            );
        end
    end

endmodule

// ==== list.f ====
hdl/nc_pkg.sv
hdl/bf16_pe.sv
hdl/step_counter.sv
hdl/frame_receiver.sv
hdl/matmul_control.sv
hdl/systolic_array.sv
hdl/result_sender.sv
hdl/neural_chip.sv
sim/tb_neural_chip.sv

// ==== sim/tb_neural_chip.sv ====
`timescale 1ns/1ps

module tb_neural_chip import nc_pkg::*; ();

    localparam int N           = 2;
    localparam int RESP_BYTES  = 2 * N * N + 2;     // Start, C, end
    localparam int FRAME_BYTES = 4 * N * N + 2;     // Start, A, B, end
    localparam int WORST_STALL = 8;                 // Cycles per byte with ready toggling
    localparam int N_FRAMES    = 8;                 // Frames over all tests, junk included
    localparam int RESP_WAIT   = RESP_BYTES * 4 * WORST_STALL + 100;
    localparam int WATCHDOG_CYCLES =
        4 * N_FRAMES * (FRAME_BYTES + 3 * N + RESP_BYTES * 2 * WORST_STALL + 40);

    logic  clk, reset;
    logic  rx_valid_i, tx_ready_i;
    byte_t rx_data_i;
    logic  tx_valid_o, mult_done_o;
    byte_t tx_data_o;

    logic [15:0] lfsr_q   = 16'd59;
    logic        stall_en = 1'b0;       // Ready driven by LFSR when set
    byte_t       resp_q [$];            // Bytes seen on tx
    int          done_cnt, done_at_first_tx, ready_viol;
    int          errors, test_errs, failed_tests, tests_run;
    int          a_m [N][N];            // Operands as plain integers
    int          b_m [N][N];

    neural_chip #(.ARRAY_N(N)) u_dut (
        .clk, .reset,
        .rx_valid_i, .rx_data_i,
        .tx_ready_i,
        .tx_valid_o, .tx_data_o,
        .mult_done_o
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Galois LFSR, one step for each bit taken
    function automatic int unsigned rand_bits(int n);
        int unsigned v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            v      = (v << 1) | lfsr_q[0];
            lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 16'hB400 : lfsr_q >> 1;
        end
        return v;
    endfunction

    // Small integer to bfloat16, exact below 256
    function automatic bf16_t int_to_bf16(int v);
        int unsigned mag;
        int          msb;
        mag = (v < 0) ? -v : v;
        msb = 0;
        if (mag == 0) return '0;
        for (int k = 0; k < 8; k++) begin
            if (mag[k]) msb = k;
        end
        return {1'(v < 0), 8'(127 + msb), 7'(mag << (7 - msb))};   // Hidden bit dropped
    endfunction

    function automatic int c_model(int i, int c);
        int acc;
        acc = 0;
        for (int k = 0; k < N; k++) acc += a_m[i][k] * b_m[k][c];
        return acc;
    endfunction

    // Output monitor, samples at the edge like the DUT does
    always @(posedge clk) begin
        if (mult_done_o) done_cnt++;
        if (tx_valid_o && !tx_ready_i) ready_viol++;
        if (tx_valid_o) begin
            if (resp_q.size() == 0) done_at_first_tx = done_cnt;
            resp_q.push_back(tx_data_o);
        end
    end

    always @(posedge clk) begin
        if (stall_en) tx_ready_i <= 1'(rand_bits(1));
        else tx_ready_i <= 1'b1;
    end

    task automatic clear_monitor();
        resp_q.delete();
        done_cnt         = 0;
        done_at_first_tx = -1;
        ready_viol       = 0;
    endtask

    task automatic send_byte(byte_t b);
        @(posedge clk);
        rx_valid_i <= 1'b1;     // Strobes may run back to back
        rx_data_i  <= b;
    endtask

    task automatic release_rx();
        @(posedge clk);
        rx_valid_i <= 1'b0;
    endtask

    task automatic fill_random(int lo);
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                a_m[r][c] = lo + int'(rand_bits(3));
                b_m[r][c] = lo + int'(rand_bits(3));
            end
        end
    endtask

    // Start, A row-major, B row-major, end
    task automatic send_frame();
        bf16_t e;
        send_byte(FRAME_START);
        for (int m = 0; m < 2; m++) begin
            for (int r = 0; r < N; r++) begin
                for (int c = 0; c < N; c++) begin
                    e = int_to_bf16(m == 0 ? a_m[r][c] : b_m[r][c]);
                    send_byte(e[15:8]);
                    send_byte(e[7:0]);
                end
            end
        end
        send_byte(FRAME_END);
        release_rx();
    endtask

    task automatic check_response();
        byte_t exp_q [$];
        bf16_t e;
        int    waited;
        exp_q.push_back(FRAME_START);
        for (int i = 0; i < N; i++) begin
            for (int c = 0; c < N; c++) begin
                e = int_to_bf16(c_model(i, c));
                exp_q.push_back(e[15:8]);
                exp_q.push_back(e[7:0]);
            end
        end
        exp_q.push_back(FRAME_END);
        waited = 0;
        while (resp_q.size() < RESP_BYTES && waited < RESP_WAIT) begin
            @(posedge clk);
            waited++;
        end
        repeat (3) @(posedge clk);              // Controller returns to idle
        if (resp_q.size() != RESP_BYTES) begin
            $display("Response incomplete or too long, %0d bytes seen", resp_q.size());
            test_errs++;
        end else begin
            for (int k = 0; k < RESP_BYTES; k++) begin
                if (resp_q[k] !== exp_q[k]) begin
                    $display("Mismatch tx_data_o byte %0d: got 0x%02h, expected 0x%02h",
                             k, resp_q[k], exp_q[k]);
                    test_errs++;
                end
            end
        end
        if (ready_viol != 0) begin
            $display("tx_valid_o was high while tx_ready_i was low in %0d cycles", ready_viol);
            test_errs++;
        end
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("Test %s: pass", name);
        end else begin
            $display("Test %s: %0d errors", name, test_errs);
            failed_tests++;
        end
        errors   += test_errs;
        test_errs = 0;
    endtask

    task automatic test_identity();
        fill_random(1);
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) a_m[r][c] = (r == c);   // C comes back as B
        end
        clear_monitor();
        send_frame();
        check_response();
        if (done_cnt != 1) begin
            $display("mult_done_o pulsed %0d times, expected once", done_cnt);
            test_errs++;
        end
        if (done_at_first_tx != 1) begin
            $display("mult_done_o did not pulse before the first tx byte");
            test_errs++;
        end
        finish_test("identity");
    endtask

    task automatic test_general();
        fill_random(1);                 // 1 to 8
        clear_monitor();
        send_frame();
        check_response();
        finish_test("general product");
    endtask

    // Every sum adds same-sign terms or a zero
    task automatic test_signs();
        a_m = '{'{-2, 0}, '{3, -1}};
        b_m = '{'{4, -5}, '{0, 2}};
        clear_monitor();
        send_frame();
        check_response();
        finish_test("signs and zeros");
    endtask

    task automatic test_framing();
        fill_random(1);
        clear_monitor();
        send_byte(8'h12);               // Noise ahead of the start byte
        send_byte(FRAME_END);
        send_byte(8'h00);
        send_frame();
        repeat (3) @(posedge clk);      // Engine now busy
        send_byte(FRAME_START);
        repeat (4 * N * N) send_byte(8'h40);
        send_byte(FRAME_END);
        release_rx();
        check_response();
        repeat (40) @(posedge clk);     // Room for a second frame that must not come
        if (resp_q.size() != RESP_BYTES || done_cnt != 1) begin
            $display("Frame sent while busy produced extra output");
            test_errs++;
        end
        finish_test("framing");
    endtask

    task automatic test_backpressure();
        fill_random(1);                 // Before the stall process takes LFSR bits
        clear_monitor();
        @(posedge clk);
        stall_en <= 1'b1;
        send_frame();
        check_response();
        stall_en <= 1'b0;
        repeat (2) @(posedge clk);
        finish_test("back-pressure");
    endtask

    task automatic test_back_to_back();
        fill_random(1);
        clear_monitor();
        send_frame();
        check_response();
        fill_random(0);                 // Zeros show stale results
        clear_monitor();
        send_frame();
        check_response();
        finish_test("back-to-back");
    endtask

    initial begin
        reset        = 1'b0;
        rx_valid_i   = 1'b0;
        rx_data_i    = '0;
        tx_ready_i   = 1'b1;
        errors       = 0;
        test_errs    = 0;
        failed_tests = 0;
        tests_run    = 0;
        clear_monitor();
        repeat (3) @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        test_identity();
        test_general();
        test_signs();
        test_framing();
        test_backpressure();
        test_back_to_back();
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, failed_tests, errors);
        if (errors == 0) $display("Done: no errors");
        else $display("Done: errors found");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule
